// File: sim.f
+incdir+.
decim_data_pkg.sv
decim_ctrl_pkg.sv
decim_control.sv
coeff_store.sv
sample_store.sv
mac_unit.sv
output_round.sv
decim_filter.sv
decim_filter_assert.sv
tb_decim_filter.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and returns its status

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_decim_filter -f sim.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_decim_filter; then
	echo "Simulation run returned an error status"
	exit 1
fi

exit 0

// File: tb_decim_filter.sv
/*
 * Testbench for the decimating FIR filter
 * Applies a table of coefficient loads and sample bursts, predicts each
 * output from the filter equation and checks its value and its timing
 */
`timescale 1ns/1ps
`include "decim_macros.svh"

module tb_decim_filter;

	localparam int TAPS          = `DECIM_NUM_TAPS;
	localparam int RATIO         = `DECIM_RATIO;
	// Cycles from a group start strobe to its output strobe
	localparam int LATENCY       = 12;
	localparam int VALID_TIMEOUT = 40;
	localparam int DRAIN_TIMEOUT = 200;
	// Accumulator bits below the output LSB
	localparam int FRAC_W  = `DECIM_ACC_W - `DECIM_OUT_SHIFT - `DECIM_OUT_W;
	localparam longint OUT_MAX = (longint'(1) <<< (`DECIM_OUT_W - 1)) - 1;
	localparam longint OUT_MIN = -(longint'(1) <<< (`DECIM_OUT_W - 1));

	// Step kinds of the stimulus table
	localparam int ST_COEFF   = 0;
	localparam int ST_RCOEFF  = 1;
	localparam int ST_SAMPLE  = 2;
	localparam int ST_RSAMPLE = 3;
	localparam int ST_DRAIN   = 4;
	localparam int NUM_STEPS  = 18;

	// Each row holds the step kind, a repeat count and a fixed value
	localparam int STIM [NUM_STEPS][3] = '{
		// Impulse at tap 3
		'{ST_COEFF, 3, 0}, '{ST_COEFF, 1, 1}, '{ST_COEFF, 4, 0},
		'{ST_RSAMPLE, 24, 0}, '{ST_DRAIN, 0, 0},
		// Random taps and samples
		'{ST_RCOEFF, 8, 0}, '{ST_RSAMPLE, 40, 0}, '{ST_DRAIN, 0, 0},
		// Full scale windows that overflow in both directions
		'{ST_COEFF, 8, 2047}, '{ST_SAMPLE, 16, 32767}, '{ST_DRAIN, 0, 0},
		'{ST_COEFF, 8, -2048}, '{ST_SAMPLE, 16, 32767}, '{ST_SAMPLE, 16, -32768},
		'{ST_DRAIN, 0, 0},
		// Nine writes so the last one lands on tap 0 again
		'{ST_RCOEFF, 9, 0}, '{ST_RSAMPLE, 32, 0}, '{ST_DRAIN, 0, 0}
	};

	logic                    i_clk;
	logic                    i_reset;
	logic                    i_tap_wr;
	decim_data_pkg::coeff_t  i_tap;
	logic                    i_sample_stb;
	decim_data_pkg::sample_t i_sample;
	logic                    o_valid;
	decim_data_pkg::result_t o_result;

	// Reference model state
	int          coeff_model [TAPS];
	int          coeff_ptr;
	int          sample_hist [$];
	int          sample_count;
	int          cyc = 0;
	logic [15:0] lfsr_state;

	// Pending outputs with one entry per group start
	int valid_cycle_q [$];
	int exp_result_q [$];
	bit exp_defined_q [$];

	decim_filter i_decim_filter (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_tap_wr     (i_tap_wr),
		.i_tap        (i_tap),
		.i_sample_stb (i_sample_stb),
		.i_sample     (i_sample),
		.o_valid      (o_valid),
		.o_result     (o_result)
	);

	bind decim_filter decim_filter_assert u_decim_assert (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_sample_stb (i_sample_stb),
		.i_valid      (o_valid),
		.i_result     (o_result)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// Counts rising edges so expected output cycles can be stamped
	always @(posedge i_clk)
		cyc <= cyc + 1;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Fibonacci LFSR on x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			bits       = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// Sum of h[k] * x[m-7+k], rounded to nearest even and clamped to full scale
	function automatic int predict_output(input int m);
		longint acc;
		longint q;
		longint rem;
		acc = 0;
		for (int k = 0; k < TAPS; k++)
			acc += longint'(coeff_model[k]) * longint'(sample_hist[m - TAPS + 1 + k]);
		q   = acc >>> FRAC_W;
		rem = acc - (q <<< FRAC_W);
		if (rem > (1 << (FRAC_W - 1)) || (rem == (1 << (FRAC_W - 1)) && (q & 1) != 0))
			q = q + 1;
		if (q > OUT_MAX)
			q = OUT_MAX;
		else if (q < OUT_MIN)
			q = OUT_MIN;
		return int'(q);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// The model pointer wraps the same way as the coefficient port
	task automatic write_coeff(input int value);
		i_tap_wr               = 1'b1;
		i_tap                  = decim_data_pkg::coeff_t'(value);
		coeff_model[coeff_ptr] = value;
		coeff_ptr              = (coeff_ptr + 1) % TAPS;
		@(posedge i_clk);
		#1 i_tap_wr = 1'b0;
	endtask

	task automatic send_sample(input int value);
		int m;
		m            = sample_count;
		i_sample_stb = 1'b1;
		i_sample     = decim_data_pkg::sample_t'(value);
		sample_hist.push_back(value);
		sample_count++;
		if (m % RATIO == 0)
		begin
			valid_cycle_q.push_back(cyc + LATENCY);
			// Windows that reach before the first sample have no defined value
			exp_defined_q.push_back(m >= TAPS - 1);
			if (m >= TAPS - 1)
				exp_result_q.push_back(predict_output(m));
			else
				exp_result_q.push_back(0);
		end
		@(posedge i_clk);
		#1 i_sample_stb = 1'b0;
		// Two idle cycles keep strobes three cycles apart
		repeat (2)
		begin
			@(posedge i_clk);
			#1;
		end
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (exp_result_q.size() != 0 || valid_cycle_q.size() != 0)
		begin
			@(posedge i_clk);
			#1 waited++;
			if (waited > DRAIN_TIMEOUT)
				fail_run("Timeout while waiting for the pending outputs to appear");
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output checks
	////////////////////////////////////////////////////////////

	// Strobe must land exactly on the stamped cycle and nowhere else
	always @(negedge i_clk)
	begin : valid_timing
		logic exp_valid;
		if (!i_reset)
		begin
			exp_valid = (valid_cycle_q.size() != 0) && (valid_cycle_q[0] == cyc);
			check_value("o_valid", 32'(o_valid), 32'(exp_valid));
			if (exp_valid)
				void'(valid_cycle_q.pop_front());
		end
	end

	initial
	begin : result_checker
		int waited;
		forever
		begin
			@(negedge i_clk);
			if (exp_result_q.size() != 0)
			begin
				waited = 0;
				while (!o_valid)
				begin
					@(negedge i_clk);
					waited++;
					if (waited > VALID_TIMEOUT)
						fail_run("Timeout while waiting for o_valid");
				end
				if (exp_defined_q[0])
					check_value("o_result", 32'(o_result), 32'(exp_result_q[0]));
				void'(exp_result_q.pop_front());
				void'(exp_defined_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin : stimulus
		int kind;
		int count;
		int value;
		i_reset      = 1'b1;
		i_tap_wr     = 1'b0;
		i_tap        = '0;
		i_sample_stb = 1'b0;
		i_sample     = '0;
		lfsr_state   = 16'd15793;
		coeff_ptr    = 0;
		sample_count = 0;
		for (int k = 0; k < TAPS; k++)
			coeff_model[k] = 0;
		repeat (5) @(posedge i_clk);
		#1 i_reset = 1'b0;

		for (int s = 0; s < NUM_STEPS; s++)
		begin
			kind  = STIM[s][0];
			count = STIM[s][1];
			value = STIM[s][2];
			case (kind)
				ST_COEFF:
					repeat (count) write_coeff(value);
				ST_RCOEFF:
					repeat (count)
						write_coeff(int'(decim_data_pkg::coeff_t'(take_bits(`DECIM_COEFF_W))));
				ST_SAMPLE:
					repeat (count) send_sample(value);
				ST_RSAMPLE:
					repeat (count)
						send_sample(int'(decim_data_pkg::sample_t'(take_bits(`DECIM_IN_W))));
				default:
					drain_outputs();
			endcase
		end

		drain_outputs();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: decim_filter_assert.sv
/*
 * Protocol assertions for the decimating FIR filter
 * Bound to the top level, watches the output strobe, the result register
 * and the spacing of input sample strobes
 */
`timescale 1ns/1ps

module decim_filter_assert (
	input logic                    i_clk,
	input logic                    i_reset,
	input logic                    i_sample_stb,
	input logic                    i_valid,
	input decim_data_pkg::result_t i_result
);

	// Set once the first result has been registered
	logic have_result;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			have_result <= 1'b0;
		else if (i_valid)
			have_result <= 1'b1;
	end

	// The output strobe lasts a single cycle
	valid_single: assert property (@(posedge i_clk) disable iff (i_reset)
		i_valid |=> !i_valid)
		else $error("o_valid was high in two consecutive cycles");

	// Nothing comes out right after reset
	valid_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_valid)
		else $error("o_valid was high in the cycle after reset");

	// The result only moves together with the strobe
	result_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		have_result && !i_valid |-> $stable(i_result))
		else $error("o_result changed without o_valid");

	// Sample strobes need at least three cycles between them
	strobe_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
		i_sample_stb |-> !$past(i_sample_stb) && !$past(i_sample_stb, 2))
		else $error("Sample strobes closer than three cycles");

endmodule

// File: decim_filter.sv
/*
 * Decimating FIR filter top level
 * One output per DECIM_RATIO samples from NUM_TAPS taps, with a single
 * multiplier shared across taps one per clock
 */
`timescale 1ns/1ps

module decim_filter (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_tap_wr,
	input  decim_data_pkg::coeff_t  i_tap,
	input  logic                    i_sample_stb,
	input  decim_data_pkg::sample_t i_sample,
	output logic                    o_valid,
	output decim_data_pkg::result_t o_result
);

	logic                     run_start;
	decim_ctrl_pkg::tap_idx_t tap_idx;
	logic                     first_prod;
	logic                     acc_en;
	logic                     acc_done;
	decim_data_pkg::coeff_t   rd_coeff;
	decim_data_pkg::sample_t  rd_sample;
	decim_data_pkg::acc_t     acc;

	decim_control u_control (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_sample_stb (i_sample_stb),
		.o_run_start  (run_start),
		.o_tap_idx    (tap_idx),
		.o_first_prod (first_prod),
		.o_acc_en     (acc_en),
		.o_acc_done   (acc_done)
	);

	// Both stores read in one cycle so tap and sample meet at the multiplier
	coeff_store u_coeff (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_tap_wr  (i_tap_wr),
		.i_tap     (i_tap),
		.i_tap_idx (tap_idx),
		.o_coeff   (rd_coeff)
	);

	sample_store u_samples (
		.i_clk        (i_clk),
		.i_sample_stb (i_sample_stb),
		.i_sample     (i_sample),
		.i_run_start  (run_start),
		.o_sample     (rd_sample)
	);

	mac_unit u_mac (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_sample     (rd_sample),
		.i_coeff      (rd_coeff),
		.i_first_prod (first_prod),
		.i_acc_en     (acc_en),
		.o_acc        (acc)
	);

	output_round u_round (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_acc      (acc),
		.i_acc_done (acc_done),
		.o_valid    (o_valid),
		.o_result   (o_result)
	);

endmodule

// File: output_round.sv
/*
 * Output scaling
 * Drops the top guard bits, rounds the low bits away to nearest even
 * and clamps to full scale on overflow, then registers the result
 */
`timescale 1ns/1ps
`include "decim_macros.svh"

module output_round (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  decim_data_pkg::acc_t    i_acc,
	input  logic                    i_acc_done,
	output logic                    o_valid,
	output decim_data_pkg::result_t o_result
);

	localparam int ACC_W  = `DECIM_ACC_W;
	localparam int OUT_W  = `DECIM_OUT_W;
	// Low bits below the output LSB that get rounded off
	localparam int DROP_W = ACC_W - `DECIM_OUT_SHIFT - OUT_W;

	logic               round_up;
	// One spare bit on top so the rounding carry can never wrap
	logic [ACC_W-DROP_W:0] rounded;
	logic               overflow;
	logic               sgn;

	// Round up above half, and at exactly half only when the LSB is odd
	assign round_up = i_acc[DROP_W-1] && ((|i_acc[DROP_W-2:0]) || i_acc[DROP_W]);

	assign rounded = {i_acc[ACC_W-1], i_acc[ACC_W-1:DROP_W]}
		+ {{(ACC_W-DROP_W){1'b0}}, round_up};

	assign sgn = rounded[ACC_W-DROP_W];

	// Guard bits and the output sign must all agree, including after the carry
	assign overflow = !(&rounded[ACC_W-DROP_W:OUT_W-1]) && (|rounded[ACC_W-DROP_W:OUT_W-1]);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_acc_done;
	end

	// Result holds between done strobes
	always_ff @(posedge i_clk)
	begin
		if (i_acc_done)
		begin
			if (overflow)
				o_result <= sgn ? {1'b1, {(OUT_W-1){1'b0}}} : {1'b0, {(OUT_W-1){1'b1}}};
			else
				o_result <= rounded[OUT_W-1:0];
		end
	end

endmodule

// File: mac_unit.sv
/*
 * Shared multiply and accumulate
 * One registered signed product per cycle, summed into a sign extended
 * accumulator that restarts on the first product of each run
 */
`timescale 1ns/1ps

module mac_unit (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  decim_data_pkg::sample_t  i_sample,
	input  decim_data_pkg::coeff_t   i_coeff,
	input  logic                     i_first_prod,
	input  logic                     i_acc_en,
	output decim_data_pkg::acc_t     o_acc
);

	// Headroom bits above the product, one per doubling of the tap count
	localparam int EXT_W = $bits(decim_data_pkg::acc_t) - $bits(decim_data_pkg::product_t);

	decim_data_pkg::product_t prod_q;
	decim_data_pkg::acc_t     prod_ext;

	// Both operands are signed so the multiply is signed
	always_ff @(posedge i_clk)
		prod_q <= i_sample * i_coeff;

	assign prod_ext = {{EXT_W{prod_q[$bits(prod_q)-1]}}, prod_q};

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_acc <= '0;
		else if (i_first_prod)
			// Start a fresh sum, nothing from the last run carries over
			o_acc <= prod_ext;
		else if (i_acc_en)
			o_acc <= o_acc + prod_ext;
	end

endmodule

// File: sample_store.sv
/*
 * Circular sample buffer
 * Keeps the last NUM_TAPS input samples and reads them out oldest first,
 * one per cycle, once a run begins
 */
`timescale 1ns/1ps
`include "decim_macros.svh"

module sample_store (
	input  logic                    i_clk,
	input  logic                    i_sample_stb,
	input  decim_data_pkg::sample_t i_sample,
	input  logic                    i_run_start,
	output decim_data_pkg::sample_t o_sample
);

	decim_data_pkg::sample_t mem [`DECIM_NUM_TAPS];
	// Slot of the most recent sample; only pointer offsets matter here
	decim_ctrl_pkg::tap_idx_t wr_ptr = '0;
	decim_ctrl_pkg::tap_idx_t wr_next;
	decim_ctrl_pkg::tap_idx_t rd_ptr = '0;
	decim_ctrl_pkg::tap_idx_t rd_addr;

	assign wr_next = decim_ctrl_pkg::tap_idx_t'(wr_ptr + 1'b1);

	// The slot after the newest sample holds the oldest one
	assign rd_addr = i_run_start ? wr_next : rd_ptr;

	always_ff @(posedge i_clk)
	begin
		if (i_sample_stb)
		begin
			wr_ptr       <= wr_next;
			mem[wr_next] <= i_sample;
		end
		// Free running outside a run, the start strobe reloads it
		rd_ptr   <= decim_ctrl_pkg::tap_idx_t'(rd_addr + 1'b1);
		o_sample <= mem[rd_addr];
	end

endmodule

// File: coeff_store.sv
/*
 * Coefficient memory
 * Taps are written in order through a wrapping pointer and read back
 * through a register at the index given by the sequencer
 */
`timescale 1ns/1ps
`include "decim_macros.svh"

module coeff_store (
	input  logic                     i_clk,
	input  logic                     i_reset,
	input  logic                     i_tap_wr,
	input  decim_data_pkg::coeff_t   i_tap,
	input  decim_ctrl_pkg::tap_idx_t i_tap_idx,
	output decim_data_pkg::coeff_t   o_coeff
);

	decim_data_pkg::coeff_t   mem [`DECIM_NUM_TAPS];
	decim_ctrl_pkg::tap_idx_t wr_ptr;

	// Pointer wraps on its own since the depth is a power of two
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			wr_ptr <= '0;
		else if (i_tap_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_tap_wr)
			mem[wr_ptr] <= i_tap;
		// One cycle read, aligned with the sample buffer read
		o_coeff <= mem[i_tap_idx];
	end

endmodule

// File: decim_control.sv
/*
 * Decimation and tap sequencing control
 * Picks the group start strobes, steps the tap index through one run
 * and delays the run marker into the multiply and accumulate strobes
 */
`timescale 1ns/1ps
`include "decim_macros.svh"

module decim_control (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  logic                    i_sample_stb,
	output logic                    o_run_start,
	output decim_ctrl_pkg::tap_idx_t o_tap_idx,
	output logic                    o_first_prod,
	output logic                    o_acc_en,
	output logic                    o_acc_done
);

	localparam decim_ctrl_pkg::ratio_cnt_t LAST_CNT =
		decim_ctrl_pkg::ratio_cnt_t'(`DECIM_RATIO - 1);
	localparam decim_ctrl_pkg::tap_idx_t LAST_TAP =
		decim_ctrl_pkg::tap_idx_t'(`DECIM_NUM_TAPS - 1);

	decim_ctrl_pkg::ratio_cnt_t   ratio_cnt;
	decim_ctrl_pkg::seq_state_t   state;
	logic                         group_start;
	// Bit 0 trails the issue stage by one cycle, bit 2 by three
	logic [2:0]                   run_pipe;

	////////////////////////////////////////////////////////////
	// Decimation counter
	////////////////////////////////////////////////////////////

	// A zero count means this strobe opens a new group
	assign group_start = i_sample_stb && (ratio_cnt == '0);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			ratio_cnt <= '0;
		else if (i_sample_stb)
		begin
			if (ratio_cnt == LAST_CNT)
				ratio_cnt <= '0;
			else
				ratio_cnt <= ratio_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Tap sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state       <= decim_ctrl_pkg::SEQ_IDLE;
			o_tap_idx   <= '0;
			o_run_start <= 1'b0;
		end
		else
		begin
			o_run_start <= group_start;
			case (state)
				decim_ctrl_pkg::SEQ_IDLE:
				begin
					// Tap 0 goes out in the cycle after the group start strobe
					o_tap_idx <= '0;
					if (group_start)
						state <= decim_ctrl_pkg::SEQ_RUN;
				end
				default:
				begin
					o_tap_idx <= o_tap_idx + 1'b1;
					if (o_tap_idx == LAST_TAP)
						state <= decim_ctrl_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pipeline strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			run_pipe <= '0;
		else
			run_pipe <= {run_pipe[1:0], state == decim_ctrl_pkg::SEQ_RUN};
	end

	// Two cycles after issue lines up with the product register
	assign o_acc_en     = run_pipe[1];
	// Runs are separated by idle cycles, so edges mark first and last products
	assign o_first_prod = run_pipe[1] && !run_pipe[2];
	// Accumulator holds the finished sum one cycle after the last product
	assign o_acc_done   = run_pipe[2] && !run_pipe[1];

endmodule

// File: decim_ctrl_pkg.sv
/*
 * Control types for the decimating FIR filter
 * Sequencer states plus the tap index and decimation counter vectors
 */
`include "decim_macros.svh"

package decim_ctrl_pkg;

	// Addresses both the coefficient memory and the sample buffer
	typedef logic [`DECIM_TAP_W-1:0] tap_idx_t;

	// Counts input strobes within one decimation group
	typedef logic [`DECIM_RATIO_W-1:0] ratio_cnt_t;

	// Idle between outputs, run while the taps are being issued
	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

endpackage

// File: decim_data_pkg.sv
/*
 * Datapath types for the decimating FIR filter
 * Signed vectors for samples, coefficients, products, the accumulator
 * and the rounded output
 */
`include "decim_macros.svh"

package decim_data_pkg;

	// Raw input sample from the source
	typedef logic signed [`DECIM_IN_W-1:0] sample_t;

	// Filter tap value as written through the coefficient port
	typedef logic signed [`DECIM_COEFF_W-1:0] coeff_t;

	// Full precision product of one sample and one tap
	typedef logic signed [`DECIM_IN_W+`DECIM_COEFF_W-1:0] product_t;

	// Running sum over all taps of one output
	typedef logic signed [`DECIM_ACC_W-1:0] acc_t;

	// Rounded and saturated filter output
	typedef logic signed [`DECIM_OUT_W-1:0] result_t;

endpackage

// File: decim_macros.svh
/*
 * Build constants for the decimating FIR filter
 * Sets the datapath widths, the tap count, the decimation ratio and the
 * number of accumulator guard bits dropped at the output
 */
`ifndef DECIM_MACROS_SVH
`define DECIM_MACROS_SVH

// Input sample, coefficient and output widths
`define DECIM_IN_W      16
`define DECIM_COEFF_W   12
`define DECIM_OUT_W     24

// Tap count is a power of two so the sample buffer depth matches it
`define DECIM_NUM_TAPS  8
`define DECIM_TAP_W     3

// One output for every DECIM_RATIO input samples
`define DECIM_RATIO     4
`define DECIM_RATIO_W   2

// Top accumulator bits thrown away before rounding
`define DECIM_OUT_SHIFT 2
// Wide enough to sum NUM_TAPS full scale products without overflow
`define DECIM_ACC_W     (`DECIM_IN_W + `DECIM_COEFF_W + `DECIM_TAP_W)

`endif
